//--- verilog.f
hw/wb_errgen_pkg.sv
hw/wb_req_filter.sv
hw/wb_rsp_order_fifo.sv
hw/wb_rsp_merge.sv
hw/wb_error_generator.sv
tests/wb_error_generator_sva.sv
tests/tb_wb_error_generator.sv

//--- Bender.yml
package:
  name: wb_error_generator

sources:
  # design sources, package first
  - files:
      - hw/wb_errgen_pkg.sv
      - hw/wb_req_filter.sv
      - hw/wb_rsp_order_fifo.sv
      - hw/wb_rsp_merge.sv
      - hw/wb_error_generator.sv

  # testbench with bound assertions
  - target: simulation
    files:
      - tests/wb_error_generator_sva.sv
      - tests/tb_wb_error_generator.sv

//--- tests/tb_wb_error_generator.sv
// Testbench for the Wishbone error generator
// Drives pipelined initiator requests, models an in-order target with
// random latency and checks every response against an in-order scoreboard.
`timescale 1ns/1ps
`default_nettype none

module tb_wb_error_generator;
   import wb_errgen_pkg::*;

   localparam int MAX_CYCLES = 3000;                  // six tests, each well below 300 cycles
   localparam int SEED       = 32'h3c1f;

   logic    clk_i, rst_i;
   logic    itr_cyc_i, itr_stb_i, itr_we_i;
   sel_t    itr_sel_i, tgt_sel_o;
   adr_t    itr_adr_i, tgt_adr_o;
   dat_t    itr_dat_i, itr_dat_o, tgt_dat_i, tgt_dat_o;
   tgtsel_t itr_tga_tgtsel_i, tgt_tga_tgtsel_o;
   logic    itr_ack_o, itr_err_o, itr_rty_o, itr_stall_o;
   logic    tgt_cyc_o, tgt_stb_o, tgt_we_o;
   logic    tgt_ack_i, tgt_err_i, tgt_rty_i, tgt_stall_i;

   logic exp_gen_q[$];                                // 1 = generated error expected
   adr_t exp_adr_q[$];                                // address per outstanding request
   int   plan_q[$];                                   // delay*4 + kind, per valid request
   adr_t tq_adr[$];                                   // target model queue
   int   tq_plan[$];
   logic tgt_hold;                                    // target withholds answers
   int   err_cnt, err_mark, cycle_cnt, stall_cycles, test_cnt, fail_tests;
   int   stalls, mark;

   wb_error_generator wb_error_generator_inst (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;                      // 8 ns period
   end

   function automatic dat_t rsp_data(input adr_t adr);
      return {adr[7:0], adr[15:8]} ^ 16'h3c5a;        // read data keyed to address
   endfunction

   function automatic int pick_plan(input bit mix);
      return $urandom_range(1, 3) * 4 + (mix ? $urandom_range(0, 2) : 0);
   endfunction

   function automatic tgtsel_t pick_tgtsel();
      return ($urandom_range(0, 3) == 0) ? '0 : tgtsel_t'($urandom_range(1, 15));
   endfunction

   function automatic int total_errors();
      return err_cnt + wb_error_generator_inst.wb_error_generator_sva_inst.fail_cnt;
   endfunction

   task automatic flag_mismatch(input string msg);
      $display("Fail at %0t ns: %s", $time, msg);
      err_cnt++;
   endtask

   //----------------------------------------------------------------------
   // target model, in order, latency from plan_q
   //----------------------------------------------------------------------
   always @(posedge clk_i)
   begin
      if (!tgt_cyc_o)
      begin
         tq_adr.delete();                             // cycle ended, drop all
         tq_plan.delete();
      end
      else if (tgt_stb_o && !tgt_stall_i)
      begin
         tq_adr.push_back(tgt_adr_o);
         tq_plan.push_back((plan_q.size() > 0) ? plan_q.pop_front() : 4);
      end
   end

   always @(negedge clk_i)
   begin
      tgt_ack_i = 1'b0;
      tgt_err_i = 1'b0;
      tgt_rty_i = 1'b0;
      tgt_dat_i = dat_t'(cycle_cnt * 16'h9e37);       // junk between answers
      if (tq_plan.size() > 0 && !tgt_hold)
      begin
         if (tq_plan[0] >= 8)
            tq_plan[0] = tq_plan[0] - 4;              // still waiting
         else
         begin
            tgt_ack_i = (tq_plan[0] % 4) == 0;
            tgt_err_i = (tq_plan[0] % 4) == 1;
            tgt_rty_i = (tq_plan[0] % 4) == 2;
            tgt_dat_i = rsp_data(tq_adr.pop_front());
            void'(tq_plan.pop_front());
         end
      end
   end

   //----------------------------------------------------------------------
   // scoreboard and stall checks
   //----------------------------------------------------------------------
   always @(posedge clk_i)
   begin
      int   outstanding;
      logic must_stall;
      outstanding = exp_gen_q.size();                 // matches the order buffer count
      if (!rst_i)
      begin
         if (outstanding == 0)
            assert (!itr_ack_o && !itr_err_o && !itr_rty_o)
               else flag_mismatch("response with nothing outstanding");
         else if (exp_gen_q[0])
         begin
            assert (itr_err_o && !itr_ack_o && !itr_rty_o)
               else flag_mismatch("no generated error one cycle after acceptance");
            void'(exp_gen_q.pop_front());
            void'(exp_adr_q.pop_front());
         end
         else
         begin
            assert ({itr_ack_o, itr_err_o, itr_rty_o} == {tgt_ack_i, tgt_err_i, tgt_rty_i})
               else flag_mismatch("target response not passed to initiator");
            if (tgt_ack_i || tgt_err_i || tgt_rty_i)
            begin
               assert (itr_dat_o == rsp_data(exp_adr_q[0]))
                  else flag_mismatch("read data wrong or out of order");
               void'(exp_gen_q.pop_front());
               void'(exp_adr_q.pop_front());
            end
         end
         if (itr_cyc_i && itr_stb_i)
         begin
            must_stall = (outstanding == ORD_DEPTH)
               || ((itr_tga_tgtsel_i != '0) ? tgt_stall_i : (outstanding != 0));
            assert (itr_stall_o == must_stall) else flag_mismatch("wrong stall decision");
            if (itr_stall_o)
               stall_cycles++;
            else
            begin
               exp_gen_q.push_back(itr_tga_tgtsel_i == '0);
               exp_adr_q.push_back(itr_adr_i);
            end
         end
         if (!itr_cyc_i)
         begin
            exp_gen_q.delete();                       // flushed with the cycle
            exp_adr_q.delete();
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   //----------------------------------------------------------------------
   // initiator tasks, all entered and left on a falling edge
   //----------------------------------------------------------------------
   task automatic send_req(input tgtsel_t tsel, input int plan, output int n_stall);
      n_stall = 0;
      if (tsel != '0)
         plan_q.push_back(plan);                      // target answer for this one
      itr_stb_i        = 1'b1;
      itr_tga_tgtsel_i = tsel;
      itr_we_i         = 1'($urandom_range(0, 1));
      itr_sel_i        = sel_t'($urandom);
      itr_adr_i        = adr_t'($urandom);
      itr_dat_i        = dat_t'($urandom);
      @(posedge clk_i);
      while (itr_stall_o)
      begin
         n_stall++;
         @(posedge clk_i);
      end
      @(negedge clk_i);
      itr_stb_i = 1'b0;
   endtask

   task automatic wait_idle();
      while (exp_gen_q.size() != 0)
         @(negedge clk_i);
   endtask

   task automatic end_test(input string name);
      itr_cyc_i = 1'b0;
      @(negedge clk_i);
      test_cnt++;
      if (total_errors() != err_mark)
         fail_tests++;
      $display("test %0d %s: %0d errors", test_cnt, name, total_errors() - err_mark);
      err_mark = total_errors();
   endtask

   //----------------------------------------------------------------------
   // test sequence
   //----------------------------------------------------------------------
   initial
   begin
      void'($urandom(SEED));
      rst_i = 1'b1;
      itr_cyc_i = 1'b0;
      itr_stb_i = 1'b0;
      itr_we_i = 1'b0;
      itr_sel_i = '0;
      itr_adr_i = '0;
      itr_dat_i = '0;
      itr_tga_tgtsel_i = '0;
      tgt_ack_i = 1'b0;
      tgt_err_i = 1'b0;
      tgt_rty_i = 1'b0;
      tgt_stall_i = 1'b0;
      tgt_dat_i = '0;
      tgt_hold = 1'b0;
      repeat (10) @(negedge clk_i);
      rst_i = 1'b0;
      repeat (5) @(negedge clk_i);                    // bus stays quiet
      end_test("idle after reset");

      itr_cyc_i = 1'b1;
      send_req('0, 0, stalls);
      wait_idle();
      end_test("error on idle bus");

      itr_cyc_i = 1'b1;
      repeat (24)
         send_req(pick_tgtsel(), pick_plan(1'b1), stalls);
      wait_idle();
      end_test("mixed pipelined requests");

      itr_cyc_i = 1'b1;
      tgt_hold <= 1'b1;
      repeat (ORD_DEPTH)
         send_req(4'b0001, pick_plan(1'b0), stalls);
      mark = stall_cycles;
      fork
         send_req(4'b0010, pick_plan(1'b0), stalls);
         begin
            repeat (4) @(negedge clk_i);
            tgt_hold <= 1'b0;                         // let the first answer out
         end
      join
      assert (stall_cycles > mark) else flag_mismatch("fifth request not stalled");
      wait_idle();
      tgt_stall_i = 1'b1;
      mark = stall_cycles;
      fork
         send_req(4'b0100, pick_plan(1'b0), stalls);
         begin
            repeat (3) @(negedge clk_i);
            tgt_stall_i = 1'b0;
         end
      join
      assert (stall_cycles > mark) else flag_mismatch("target stall not passed back");
      wait_idle();
      end_test("back-pressure");

      itr_cyc_i = 1'b1;
      tgt_hold <= 1'b1;
      repeat (2)
         send_req(4'b1000, pick_plan(1'b0), stalls);
      mark = stall_cycles;
      fork
         send_req('0, 0, stalls);
         begin
            repeat (3) @(negedge clk_i);
            tgt_hold <= 1'b0;
         end
      join
      assert (stall_cycles > mark) else flag_mismatch("invalid request not held back");
      wait_idle();
      end_test("error behind outstanding requests");

      itr_cyc_i = 1'b1;
      tgt_hold <= 1'b1;
      repeat (3)
         send_req(4'b0011, pick_plan(1'b0), stalls);
      itr_cyc_i = 1'b0;                               // abandon the outstanding ones
      @(negedge clk_i);
      itr_cyc_i = 1'b1;
      tgt_hold <= 1'b0;
      send_req('0, 0, stalls);
      assert (stalls == 0) else flag_mismatch("invalid request stalled after flush");
      wait_idle();
      end_test("flush on cycle drop");

      $display("%0d tests run, %0d with errors, %0d failed checks",
               test_cnt, fail_tests, total_errors());
      if (total_errors() == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/wb_error_generator_sva.sv
// Wishbone error generator, bound port assertions
// Idle outputs after reset, error timing of requests without a target,
// forwarding of the cycle and of valid requests, stall and response strobe rules.
`timescale 1ns/1ps
`default_nettype none

module wb_error_generator_sva
   import wb_errgen_pkg::*;
(
   input wire          clk_i,
   input wire          rst_i,
   input wire          itr_cyc_i,
   input wire          itr_stb_i,
   input wire          itr_we_i,
   input wire sel_t    itr_sel_i,
   input wire adr_t    itr_adr_i,
   input wire dat_t    itr_dat_i,
   input wire tgtsel_t itr_tga_tgtsel_i,
   input wire          itr_ack_o,
   input wire          itr_err_o,
   input wire          itr_rty_o,
   input wire          itr_stall_o,
   input wire          tgt_cyc_o,
   input wire          tgt_stb_o,
   input wire          tgt_we_o,
   input wire sel_t    tgt_sel_o,
   input wire adr_t    tgt_adr_o,
   input wire dat_t    tgt_dat_o,
   input wire tgtsel_t tgt_tga_tgtsel_o,
   input wire          tgt_stall_i
);

   int unsigned fail_cnt = 0;                         // read by the testbench
   logic        req_seen_q;                           // first request since reset
   logic        acc;                                  // request accepted this cycle

   assign acc = itr_cyc_i & itr_stb_i & ~itr_stall_o;

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         req_seen_q <= 1'b0;
      else if (itr_cyc_i && itr_stb_i)
         req_seen_q <= 1'b1;                          // sticky until next reset
   end

   //----------------------------------------------------------------------
   // port properties
   //----------------------------------------------------------------------
   idle_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
      (!req_seen_q && !(itr_cyc_i && itr_stb_i))
         |-> !(itr_ack_o || itr_err_o || itr_rty_o || tgt_stb_o))
   else
   begin
      $error("Fail at %0t: strobe active before the first request", $time);
      fail_cnt++;
   end

   invalid_gets_err: assert property (@(posedge clk_i) disable iff (rst_i)
      (acc && itr_tga_tgtsel_i == '0) |-> !tgt_stb_o ##1 itr_err_o)
   else
   begin
      $error("Fail at %0t: no error one cycle after request without target", $time);
      fail_cnt++;
   end

   cyc_forwarded: assert property (@(posedge clk_i) disable iff (rst_i)
      tgt_cyc_o == itr_cyc_i)
   else
   begin
      $error("Fail at %0t: target cycle differs from initiator cycle", $time);
      fail_cnt++;
   end

   valid_forwarded: assert property (@(posedge clk_i) disable iff (rst_i)
      (acc && itr_tga_tgtsel_i != '0) |-> (tgt_stb_o && tgt_adr_o == itr_adr_i
         && tgt_dat_o == itr_dat_i && tgt_we_o == itr_we_i
         && tgt_sel_o == itr_sel_i && tgt_tga_tgtsel_o == itr_tga_tgtsel_i))
   else
   begin
      $error("Fail at %0t: valid request not forwarded intact", $time);
      fail_cnt++;
   end

   stall_rules: assert property (@(posedge clk_i) disable iff (rst_i)
      (itr_stall_o |-> !tgt_stb_o)
         and ((tgt_stall_i && itr_tga_tgtsel_i != '0) |-> itr_stall_o))
   else
   begin
      $error("Fail at %0t: stall not honoured", $time);
      fail_cnt++;
   end

   one_response: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0({itr_ack_o, itr_err_o, itr_rty_o}))
   else
   begin
      $error("Fail at %0t: more than one response strobe", $time);
      fail_cnt++;
   end

endmodule

bind wb_error_generator wb_error_generator_sva wb_error_generator_sva_inst (.*);

`default_nettype wire

//--- hw/wb_error_generator.sv
// Wishbone error generator
// Sits between one initiator port and one target port of a crossbar.
// Requests with a target select pass through; requests without one are
// answered with an error one cycle after acceptance. Up to ORD_DEPTH
// requests may be outstanding and responses return in request order.
`timescale 1ns/1ps
`default_nettype none

module wb_error_generator
   import wb_errgen_pkg::*;
(
   // clock and reset
   input  wire          clk_i,                        // module clock
   input  wire          rst_i,                        // async reset, active high

   // initiator port
   input  wire          itr_cyc_i,                    // bus cycle indicator
   input  wire          itr_stb_i,                    // access request
   input  wire          itr_we_i,                     // write enable
   input  wire sel_t    itr_sel_i,                    // byte selects
   input  wire adr_t    itr_adr_i,                    // address bus
   input  wire dat_t    itr_dat_i,                    // write data
   input  wire tgtsel_t itr_tga_tgtsel_i,             // target select tag
   output wire          itr_ack_o,                    // cycle acknowledge
   output wire          itr_err_o,                    // error indicator
   output wire          itr_rty_o,                    // retry request
   output wire          itr_stall_o,                  // access delay
   output wire dat_t    itr_dat_o,                    // read data

   // target port
   output wire          tgt_cyc_o,                    // bus cycle indicator
   output wire          tgt_stb_o,                    // access request
   output wire          tgt_we_o,                     // write enable
   output wire sel_t    tgt_sel_o,                    // byte selects
   output wire adr_t    tgt_adr_o,                    // address bus
   output wire dat_t    tgt_dat_o,                    // write data
   output wire tgtsel_t tgt_tga_tgtsel_o,             // target select tag
   input  wire          tgt_ack_i,                    // cycle acknowledge
   input  wire          tgt_err_i,                    // error indicator
   input  wire          tgt_rty_i,                    // retry request
   input  wire          tgt_stall_i,                  // access delay
   input  wire dat_t    tgt_dat_i                     // read data
);

   //----------------------------------------------------------------------
   // order buffer handshake
   //----------------------------------------------------------------------
   logic ord_push;                                    // filter to buffer
   logic ord_push_err;                                // entry flag
   logic ord_full;                                    // buffer to filter
   logic ord_empty;                                   // buffer to filter and merge
   logic ord_head_err;                                // buffer to merge
   logic ord_pop;                                     // merge to buffer

   //----------------------------------------------------------------------
   // straight pass-through
   //----------------------------------------------------------------------
   assign tgt_cyc_o        = itr_cyc_i;               // target sees the whole cycle
   assign tgt_we_o         = itr_we_i;
   assign tgt_sel_o        = itr_sel_i;
   assign tgt_adr_o        = itr_adr_i;
   assign tgt_dat_o        = itr_dat_i;
   assign tgt_tga_tgtsel_o = itr_tga_tgtsel_i;

   //----------------------------------------------------------------------
   // request side
   //----------------------------------------------------------------------
   wb_req_filter wb_req_filter_inst (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .itr_cyc_i        (itr_cyc_i),
      .itr_stb_i        (itr_stb_i),
      .itr_tga_tgtsel_i (itr_tga_tgtsel_i),
      .itr_stall_o      (itr_stall_o),
      .tgt_stall_i      (tgt_stall_i),
      .tgt_stb_o        (tgt_stb_o),
      .ord_full_i       (ord_full),
      .ord_empty_i      (ord_empty),
      .ord_push_o       (ord_push),
      .ord_push_err_o   (ord_push_err)
   );

   //----------------------------------------------------------------------
   // outstanding request order
   //----------------------------------------------------------------------
   wb_rsp_order_fifo wb_rsp_order_fifo_inst (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .itr_cyc_i        (itr_cyc_i),              // cycle end flushes
      .ord_push_i       (ord_push),
      .ord_push_err_i   (ord_push_err),
      .ord_pop_i        (ord_pop),
      .ord_full_o       (ord_full),
      .ord_empty_o      (ord_empty),
      .ord_head_err_o   (ord_head_err)
   );

   //----------------------------------------------------------------------
   // response side
   //----------------------------------------------------------------------
   wb_rsp_merge wb_rsp_merge_inst (
      .ord_empty_i      (ord_empty),
      .ord_head_err_i   (ord_head_err),
      .ord_pop_o        (ord_pop),
      .tgt_ack_i        (tgt_ack_i),
      .tgt_err_i        (tgt_err_i),
      .tgt_rty_i        (tgt_rty_i),
      .tgt_dat_i        (tgt_dat_i),
      .itr_ack_o        (itr_ack_o),
      .itr_err_o        (itr_err_o),
      .itr_rty_o        (itr_rty_o),
      .itr_dat_o        (itr_dat_o)
   );

endmodule

`default_nettype wire

//--- hw/wb_rsp_merge.sv
// Wishbone error generator, response merge
// Picks the source of the next initiator response from the head of the
// order buffer: a generated error for a request without a target, or the
// target's own strobes otherwise. Purely combinational.
`timescale 1ns/1ps
`default_nettype none

module wb_rsp_merge
   import wb_errgen_pkg::*;
(
   // order buffer head
   input  wire       ord_empty_i,                     // nothing outstanding
   input  wire       ord_head_err_i,                  // head wants a local error
   output wire       ord_pop_o,                       // response delivered

   // target response side
   input  wire       tgt_ack_i,                       // cycle acknowledge
   input  wire       tgt_err_i,                       // error indicator
   input  wire       tgt_rty_i,                       // retry request
   input  wire dat_t tgt_dat_i,                       // read data

   // initiator response side
   output wire       itr_ack_o,                       // cycle acknowledge
   output wire       itr_err_o,                       // error indicator
   output wire       itr_rty_o,                       // retry request
   output wire dat_t itr_dat_o                        // read data
);

   //----------------------------------------------------------------------
   // head decode
   //----------------------------------------------------------------------
   logic head_gen;                                    // head answered locally
   logic head_tgt;                                    // head waits for target
   logic tgt_rsp;                                     // any target strobe

   assign head_gen = ~ord_empty_i & ord_head_err_i;
   assign head_tgt = ~ord_empty_i & ~ord_head_err_i;
   assign tgt_rsp  = tgt_ack_i | tgt_err_i | tgt_rty_i;

   //----------------------------------------------------------------------
   // response strobes
   //----------------------------------------------------------------------
   // Target strobes are masked while the buffer is empty, so a late answer
   // to a flushed request never shows up at the initiator.
   assign itr_ack_o = head_tgt & tgt_ack_i;           // pass through
   assign itr_err_o = head_gen | (head_tgt & tgt_err_i); // generated or passed
   assign itr_rty_o = head_tgt & tgt_rty_i;           // pass through

   assign itr_dat_o = tgt_dat_i;                      // read data straight from target

   //----------------------------------------------------------------------
   // buffer pop
   //----------------------------------------------------------------------
   assign ord_pop_o = head_gen | (head_tgt & tgt_rsp); // one per response

endmodule

`default_nettype wire

//--- hw/wb_rsp_order_fifo.sv
// Wishbone error generator, response order buffer
// Four entry circular buffer with one flag per outstanding request. The flag
// says whether the response comes from the target or is generated locally.
// Push and pop may happen in the same cycle. The whole buffer is dropped
// whenever the initiator ends its bus cycle.
`timescale 1ns/1ps
`default_nettype none

module wb_rsp_order_fifo
   import wb_errgen_pkg::*;
(
   // clock and reset
   input  wire clk_i,                                 // module clock
   input  wire rst_i,                                 // async reset, active high

   // bus cycle
   input  wire itr_cyc_i,                             // low flushes the buffer

   // write side
   input  wire ord_push_i,                            // add one entry
   input  wire ord_push_err_i,                        // entry flag value

   // read side
   input  wire ord_pop_i,                             // head entry answered
   output wire ord_full_o,                            // ORD_DEPTH entries held
   output wire ord_empty_o,                           // no entry held
   output wire ord_head_err_o                         // head flag
);

   //----------------------------------------------------------------------
   // storage and pointers
   //----------------------------------------------------------------------
   logic     ord_flag_q [ORD_DEPTH];                  // 1 = no target selected
   ord_ptr_t wr_ptr_q;                                // next free slot
   ord_ptr_t rd_ptr_q;                                // oldest entry
   ord_cnt_t cnt_q;                                   // fill level
   logic     do_push;                                 // qualified write
   logic     do_pop;                                  // qualified read

   assign do_push = ord_push_i & ~ord_full_o;         // filter never pushes when full
   assign do_pop  = ord_pop_i & ~ord_empty_o;         // merge never pops when empty

   //----------------------------------------------------------------------
   // flag storage
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i)
   begin
      if (do_push)
      begin
         ord_flag_q[wr_ptr_q] <= ord_push_err_i;      // visible next cycle
      end
   end

   //----------------------------------------------------------------------
   // pointer and count control
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else if (!itr_cyc_i)
      begin
         wr_ptr_q <= '0;                              // cycle ended, drop all
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr_q <= ord_ptr_t'(wr_ptr_q + 1'b1);  // wraps at ORD_DEPTH
         end
         if (do_pop)
         begin
            rd_ptr_q <= ord_ptr_t'(rd_ptr_q + 1'b1);
         end
         case ({do_push, do_pop})
            2'b10:   cnt_q <= ord_cnt_t'(cnt_q + 1'b1); // push only
            2'b01:   cnt_q <= ord_cnt_t'(cnt_q - 1'b1); // pop only
            default: cnt_q <= cnt_q;                  // both or neither
         endcase
      end
   end

   //----------------------------------------------------------------------
   // status
   //----------------------------------------------------------------------
   assign ord_full_o     = (cnt_q == ord_cnt_t'(ORD_DEPTH));
   assign ord_empty_o    = (cnt_q == '0);
   assign ord_head_err_o = ord_flag_q[rd_ptr_q];      // meaningful only when not empty

endmodule

`default_nettype wire

//--- hw/wb_req_filter.sv
// Wishbone error generator, request filter
// Classifies each initiator request by its target select tag. Requests with
// a target go on to the target port; requests without one are held back
// until no response is outstanding, then accepted locally. One order buffer
// entry is pushed per accepted request.
`timescale 1ns/1ps
`default_nettype none

module wb_req_filter
   import wb_errgen_pkg::*;
(
   // clock and reset
   input  wire          clk_i,                        // module clock
   input  wire          rst_i,                        // async reset, active high

   // initiator request side
   input  wire          itr_cyc_i,                    // bus cycle indicator
   input  wire          itr_stb_i,                    // access request
   input  wire tgtsel_t itr_tga_tgtsel_i,             // target select tag
   output wire          itr_stall_o,                  // request not taken

   // target request side
   input  wire          tgt_stall_i,                  // target busy
   output wire          tgt_stb_o,                    // forwarded strobe

   // order buffer
   input  wire          ord_full_i,                   // no room for another entry
   input  wire          ord_empty_i,                  // nothing outstanding
   output wire          ord_push_o,                   // one pulse per accepted request
   output wire          ord_push_err_o                // entry needs a generated error
);

   //----------------------------------------------------------------------
   // internal signals
   //----------------------------------------------------------------------
   logic cyc_act_q;                                   // bus usable, set after reset
   logic tgt_hit;                                     // at least one target selected
   logic req_stall;                                   // combined stall decision
   logic req_acc;                                     // request accepted this cycle

   //----------------------------------------------------------------------
   // cycle activity flag
   //----------------------------------------------------------------------
   // Low only in the first clock after reset release, so nothing gets
   // pushed while the order buffer pointers are still settling.
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         cyc_act_q <= 1'b0;                           // hold off requests
      end
      else
      begin
         cyc_act_q <= 1'b1;                           // free from next clock on
      end
   end

   //----------------------------------------------------------------------
   // classification and stall
   //----------------------------------------------------------------------
   assign tgt_hit = |itr_tga_tgtsel_i;                // any select bit counts

   always_comb
   begin
      if (!cyc_act_q)
      begin
         req_stall = 1'b1;                            // just out of reset
      end
      else if (tgt_hit)
      begin
         req_stall = ord_full_i | tgt_stall_i;        // valid: room and target ready
      end
      else
      begin
         req_stall = ~ord_empty_i;                    // invalid: wait for drain
      end
   end

   assign req_acc = itr_cyc_i & itr_stb_i & ~req_stall; // wishbone acceptance

   //----------------------------------------------------------------------
   // outputs
   //----------------------------------------------------------------------
   assign itr_stall_o    = req_stall;
   assign tgt_stb_o      = req_acc & tgt_hit;         // only valid requests leave
   assign ord_push_o     = req_acc;                   // one entry each
   assign ord_push_err_o = req_acc & ~tgt_hit;        // mark for local error

endmodule

`default_nettype wire

//--- hw/wb_errgen_pkg.sv
// Wishbone error generator, shared definitions
// bus widths, order buffer depth and the vector types built on them
`default_nettype none

package wb_errgen_pkg;

   //----------------------------------------------------------------------
   // bus geometry
   //----------------------------------------------------------------------
   localparam int ADR_WIDTH = 16;                     // address bus
   localparam int DAT_WIDTH = 16;                     // read and write data
   localparam int SEL_WIDTH = 2;                      // one select per byte
   localparam int TGT_CNT   = 4;                      // target select tag bits

   //----------------------------------------------------------------------
   // order buffer
   //----------------------------------------------------------------------
   localparam int ORD_DEPTH     = 4;                  // max outstanding requests
   localparam int ORD_PTR_WIDTH = 2;                  // log2 of ORD_DEPTH

   //----------------------------------------------------------------------
   // vector types
   //----------------------------------------------------------------------
   typedef logic [ADR_WIDTH-1:0] adr_t;               // address word
   typedef logic [DAT_WIDTH-1:0] dat_t;               // data word
   typedef logic [SEL_WIDTH-1:0] sel_t;               // byte selects
   typedef logic [TGT_CNT-1:0]   tgtsel_t;            // one hot-ish target select

   typedef logic [ORD_PTR_WIDTH-1:0] ord_ptr_t;       // read or write pointer
   typedef logic [ORD_PTR_WIDTH:0]   ord_cnt_t;       // fill level, 0 to ORD_DEPTH

endpackage

`default_nettype wire
